// ==== id_branch_unit.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module id_branch_unit (
    input  logic [`ID_BR_KIND_WD-1:0] br_kind,
    input  id_pkg::inst_u             id_inst,
    input  logic [`ID_XLEN-1:0]       id_pc,
    input  logic [`ID_XLEN-1:0]       rdata1,
    input  logic [`ID_XLEN-1:0]       rdata2,
    output logic                      br_taken,
    output logic [`ID_XLEN-1:0]       br_target
);

    import id_pkg::*;

    i_fields_t           iv;
    j_fields_t           jv;
    logic [`ID_XLEN-1:0] pc_plus_4;
    logic [`ID_XLEN-1:0] br_dest;
    logic [`ID_XLEN-1:0] jump_dest;

    assign iv = id_inst.i;
    assign jv = id_inst.j;

    assign pc_plus_4 = id_pc + `ID_XLEN'd4;
    // word offset relative to the delay slot
    assign br_dest   = pc_plus_4 + {{(`ID_XLEN-18){iv.imm[15]}}, iv.imm, 2'b00};
    assign jump_dest = {pc_plus_4[`ID_XLEN-1:`ID_XLEN-4], jv.index, 2'b00};

    always_comb begin
        br_taken  = 1'b0;
        br_target = '0;
        case (br_kind)
            `ID_BR_EQ: begin
                br_taken  = rdata1 == rdata2;
                br_target = br_dest;
            end
            `ID_BR_NE: begin
                br_taken  = rdata1 != rdata2;
                br_target = br_dest;
            end
            `ID_BR_GEZ: begin
                br_taken  = !rdata1[`ID_XLEN-1];
                br_target = br_dest;
            end
            `ID_BR_LTZ: begin
                br_taken  = rdata1[`ID_XLEN-1];
                br_target = br_dest;
            end
            `ID_BR_JUMP: begin
                br_taken  = 1'b1;
                br_target = jump_dest;
            end
            `ID_BR_JREG: begin
                br_taken  = 1'b1;
                br_target = rdata1;
            end
            default: begin
                br_taken  = 1'b0;
                br_target = '0;
            end
        endcase
    end

endmodule

// ==== id_decoder.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module id_decoder (
    input  id_pkg::inst_u             id_inst,
    input  logic                      id_valid,
    input  logic                      ex_is_load,
    input  logic [`ID_RADDR_WD-1:0]   ex_waddr,
    output logic [`ID_ALU_OP_WD-1:0]  alu_op,
    output logic [`ID_SRC1_WD-1:0]    sel_src1,
    output logic [`ID_SRC2_WD-1:0]    sel_src2,
    output logic                      mem_en,
    output logic                      mem_we,
    output logic                      rf_we,
    output logic [`ID_RADDR_WD-1:0]   rf_waddr,
    output logic [`ID_BR_KIND_WD-1:0] br_kind,
    output logic                      stallreq
);

    import id_pkg::*;

    r_fields_t rv;
    i_fields_t iv;

    logic special, regimm, r_plain, r_shift;
    logic inst_addu, inst_subu, inst_and, inst_or, inst_xor, inst_nor;
    logic inst_slt, inst_sltu, inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_addiu, inst_andi, inst_ori, inst_xori, inst_lui, inst_slti, inst_sltiu;
    logic inst_lw, inst_sw, inst_beq, inst_bne, inst_bgez, inst_bltz, inst_j, inst_jal;
    logic r_alu, i_alu, shift_op, dst_rd, dst_rt;

    assign rv = id_inst.r;
    assign iv = id_inst.i;

    // an invalid stage kills every match below
    assign special = id_valid && rv.opcode == `ID_OP_SPECIAL;
    assign regimm  = id_valid && iv.opcode == `ID_OP_REGIMM;
    assign r_plain = special && rv.shamt == '0;
    assign r_shift = special && rv.rs == '0;

    assign inst_addu = r_plain && rv.funct == `ID_FN_ADDU;
    assign inst_subu = r_plain && rv.funct == `ID_FN_SUBU;
    assign inst_and  = r_plain && rv.funct == `ID_FN_AND;
    assign inst_or   = r_plain && rv.funct == `ID_FN_OR;
    assign inst_xor  = r_plain && rv.funct == `ID_FN_XOR;
    assign inst_nor  = r_plain && rv.funct == `ID_FN_NOR;
    assign inst_slt  = r_plain && rv.funct == `ID_FN_SLT;
    assign inst_sltu = r_plain && rv.funct == `ID_FN_SLTU;
    assign inst_sll  = r_shift && rv.funct == `ID_FN_SLL;
    assign inst_srl  = r_shift && rv.funct == `ID_FN_SRL;
    assign inst_sra  = r_shift && rv.funct == `ID_FN_SRA;
    assign inst_jr   = r_plain && rv.rt == '0 && rv.rd == '0 && rv.funct == `ID_FN_JR;

    assign inst_addiu = id_valid && iv.opcode == `ID_OP_ADDIU;
    assign inst_andi  = id_valid && iv.opcode == `ID_OP_ANDI;
    assign inst_ori   = id_valid && iv.opcode == `ID_OP_ORI;
    assign inst_xori  = id_valid && iv.opcode == `ID_OP_XORI;
    assign inst_lui   = id_valid && iv.opcode == `ID_OP_LUI;
    assign inst_slti  = id_valid && iv.opcode == `ID_OP_SLTI;
    assign inst_sltiu = id_valid && iv.opcode == `ID_OP_SLTIU;
    assign inst_lw    = id_valid && iv.opcode == `ID_OP_LW;
    assign inst_sw    = id_valid && iv.opcode == `ID_OP_SW;
    assign inst_beq   = id_valid && iv.opcode == `ID_OP_BEQ;
    assign inst_bne   = id_valid && iv.opcode == `ID_OP_BNE;
    assign inst_bgez  = regimm && iv.rt == `ID_RT_BGEZ;
    assign inst_bltz  = regimm && iv.rt == `ID_RT_BLTZ;
    assign inst_j     = id_valid && iv.opcode == `ID_OP_J;
    assign inst_jal   = id_valid && iv.opcode == `ID_OP_JAL;

    assign r_alu = inst_addu | inst_subu | inst_and | inst_or
                 | inst_xor | inst_nor | inst_slt | inst_sltu;
    assign i_alu = inst_addiu | inst_andi | inst_ori | inst_xori | inst_slti | inst_sltiu;
    assign shift_op = inst_sll | inst_srl | inst_sra;

    assign alu_op[`ID_ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
    assign alu_op[`ID_ALU_SUB]  = inst_subu;
    assign alu_op[`ID_ALU_SLT]  = inst_slt | inst_slti;
    assign alu_op[`ID_ALU_SLTU] = inst_sltu | inst_sltiu;
    assign alu_op[`ID_ALU_AND]  = inst_and | inst_andi;
    assign alu_op[`ID_ALU_NOR]  = inst_nor;
    assign alu_op[`ID_ALU_OR]   = inst_or | inst_ori;
    assign alu_op[`ID_ALU_XOR]  = inst_xor | inst_xori;
    assign alu_op[`ID_ALU_SLL]  = inst_sll;
    assign alu_op[`ID_ALU_SRL]  = inst_srl;
    assign alu_op[`ID_ALU_SRA]  = inst_sra;
    assign alu_op[`ID_ALU_LUI]  = inst_lui;

    // src1 bits: rs, pc, shamt from lsb up
    assign sel_src1 = {shift_op, inst_jal, r_alu | i_alu | inst_lw | inst_sw};

    // src2 bits: rt, sign-ext imm, constant 8, zero-ext imm
    assign sel_src2 = {inst_andi | inst_ori | inst_xori,
                       inst_jal,
                       inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw,
                       r_alu | shift_op};

    assign mem_en = inst_lw | inst_sw;
    assign mem_we = inst_sw;

    assign dst_rd = r_alu | shift_op;
    assign dst_rt = i_alu | inst_lui | inst_lw;
    assign rf_we  = dst_rd | dst_rt | inst_jal;

    assign rf_waddr = dst_rd   ? rv.rd :
                      dst_rt   ? rv.rt :
                      inst_jal ? `ID_LINK_REG :
                      '0;

    assign br_kind = inst_beq              ? `ID_BR_EQ   :
                     inst_bne              ? `ID_BR_NE   :
                     inst_bgez             ? `ID_BR_GEZ  :
                     inst_bltz             ? `ID_BR_LTZ  :
                     (inst_j | inst_jal)   ? `ID_BR_JUMP :
                     inst_jr               ? `ID_BR_JREG :
                     `ID_BR_NONE;

    // load in execute feeds a register read here
    assign stallreq = id_valid && ex_is_load && (ex_waddr == rv.rs || ex_waddr == rv.rt);

endmodule

// ==== id_fetch_latch.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module id_fetch_latch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`ID_STALL_WD-1:0] stall,
    input  logic [`ID_XLEN-1:0]     if_pc,
    input  logic                    if_valid,
    input  logic [`ID_XLEN-1:0]     inst_rdata,
    output logic [`ID_XLEN-1:0]     id_pc,
    output logic                    id_valid,
    output id_pkg::inst_u           id_inst
);

    logic                dec_stall;
    logic                ex_stall;
    logic                hold_en;
    logic [`ID_XLEN-1:0] hold_word;

    assign dec_stall = stall[`ID_STALL_ID];
    assign ex_stall  = stall[`ID_STALL_EX];

    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
            hold_en  <= 1'b0;
        end else if (dec_stall && !ex_stall) begin
            // bubble into execute
            id_valid <= 1'b0;
            hold_en  <= 1'b0;
        end else if (!dec_stall) begin
            id_valid <= if_valid;
            hold_en  <= 1'b0;
        end else begin
            hold_en  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!dec_stall) begin
            id_pc <= if_pc;
        end
        // memory moves on while both stages wait, keep the word seen now
        if (dec_stall && ex_stall) begin
            hold_word <= id_inst;
        end
    end

    assign id_inst = hold_en ? hold_word : inst_rdata;

endmodule

// ==== id_macros.svh ====
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// datapath widths
`define ID_XLEN         32
`define ID_RADDR_WD     5
`define ID_OP_WD        6

// stall vector, one bit per stage
`define ID_STALL_WD     6
`define ID_STALL_ID     1
`define ID_STALL_EX     2

// one-hot alu op, add sits in the msb
`define ID_ALU_OP_WD    12
`define ID_ALU_ADD      11
`define ID_ALU_SUB      10
`define ID_ALU_SLT      9
`define ID_ALU_SLTU     8
`define ID_ALU_AND      7
`define ID_ALU_NOR      6
`define ID_ALU_OR       5
`define ID_ALU_XOR      4
`define ID_ALU_SLL      3
`define ID_ALU_SRL      2
`define ID_ALU_SRA      1
`define ID_ALU_LUI      0

// operand select vectors
`define ID_SRC1_WD      3
`define ID_SRC2_WD      4

// branch kinds resolved in decode
`define ID_BR_KIND_WD   3
`define ID_BR_NONE      3'd0
`define ID_BR_EQ        3'd1
`define ID_BR_NE        3'd2
`define ID_BR_GEZ       3'd3
`define ID_BR_LTZ       3'd4
`define ID_BR_JUMP      3'd5
`define ID_BR_JREG      3'd6

// primary opcodes
`define ID_OP_SPECIAL   6'b00_0000
`define ID_OP_REGIMM    6'b00_0001
`define ID_OP_J         6'b00_0010
`define ID_OP_JAL       6'b00_0011
`define ID_OP_BEQ       6'b00_0100
`define ID_OP_BNE       6'b00_0101
`define ID_OP_ADDIU     6'b00_1001
`define ID_OP_SLTI      6'b00_1010
`define ID_OP_SLTIU     6'b00_1011
`define ID_OP_ANDI      6'b00_1100
`define ID_OP_ORI       6'b00_1101
`define ID_OP_XORI      6'b00_1110
`define ID_OP_LUI       6'b00_1111
`define ID_OP_LW        6'b10_0011
`define ID_OP_SW        6'b10_1011

// regimm rt codes
`define ID_RT_BLTZ      5'b0_0000
`define ID_RT_BGEZ      5'b0_0001

// special function codes
`define ID_FN_SLL       6'b00_0000
`define ID_FN_SRL       6'b00_0010
`define ID_FN_SRA       6'b00_0011
`define ID_FN_JR        6'b00_1000
`define ID_FN_ADDU      6'b10_0001
`define ID_FN_SUBU      6'b10_0011
`define ID_FN_AND       6'b10_0100
`define ID_FN_OR        6'b10_0101
`define ID_FN_XOR       6'b10_0110
`define ID_FN_NOR       6'b10_0111
`define ID_FN_SLT       6'b10_1010
`define ID_FN_SLTU      6'b10_1011

`define ID_LINK_REG     5'd31

`endif

// ==== id_pkg.sv ====
`include "id_macros.svh"

package id_pkg;

    typedef struct packed {
        logic [`ID_OP_WD-1:0]    opcode;
        logic [`ID_RADDR_WD-1:0] rs;
        logic [`ID_RADDR_WD-1:0] rt;
        logic [`ID_RADDR_WD-1:0] rd;
        logic [4:0]              shamt;
        logic [5:0]              funct;
    } r_fields_t;

    typedef struct packed {
        logic [`ID_OP_WD-1:0]    opcode;
        logic [`ID_RADDR_WD-1:0] rs;
        logic [`ID_RADDR_WD-1:0] rt;
        logic [15:0]             imm;
    } i_fields_t;

    typedef struct packed {
        logic [`ID_OP_WD-1:0]    opcode;
        logic [25:0]             index;
    } j_fields_t;

    // one fetched word, three ways to read it
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } inst_u;

endpackage

// ==== id_regfile.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module id_regfile (
    input  logic                    clk,
    input  logic [`ID_RADDR_WD-1:0] raddr1,
    input  logic [`ID_RADDR_WD-1:0] raddr2,
    input  logic                    we,
    input  logic [`ID_RADDR_WD-1:0] waddr,
    input  logic [`ID_XLEN-1:0]     wdata,
    output logic [`ID_XLEN-1:0]     rdata1,
    output logic [`ID_XLEN-1:0]     rdata2
);

    logic [`ID_XLEN-1:0] regs [0:(1 << `ID_RADDR_WD)-1];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 is hardwired, a same-cycle write-back wins over the array
    function automatic logic [`ID_XLEN-1:0] read_port(input logic [`ID_RADDR_WD-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

// ==== id_stage.f ====
id_pkg.sv
id_fetch_latch.sv
id_regfile.sv
id_decoder.sv
id_branch_unit.sv
id_stage.sv
id_stage_asserts.sv
tb_id_stage.sv
+incdir+.

// ==== id_stage.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module id_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ID_STALL_WD-1:0]   stall,
    input  logic [`ID_XLEN-1:0]       if_pc,
    input  logic                      if_valid,
    input  logic [`ID_XLEN-1:0]       inst_rdata,
    input  logic                      wb_we,
    input  logic [`ID_RADDR_WD-1:0]   wb_waddr,
    input  logic [`ID_XLEN-1:0]       wb_wdata,
    input  logic                      ex_is_load,
    input  logic [`ID_RADDR_WD-1:0]   ex_waddr,
    output logic                      id_valid,
    output logic [`ID_XLEN-1:0]       id_pc,
    output id_pkg::inst_u             id_inst,
    output logic [`ID_ALU_OP_WD-1:0]  alu_op,
    output logic [`ID_SRC1_WD-1:0]    sel_src1,
    output logic [`ID_SRC2_WD-1:0]    sel_src2,
    output logic                      mem_en,
    output logic                      mem_we,
    output logic                      rf_we,
    output logic [`ID_RADDR_WD-1:0]   rf_waddr,
    output logic [`ID_XLEN-1:0]       rdata1,
    output logic [`ID_XLEN-1:0]       rdata2,
    output logic                      br_taken,
    output logic [`ID_XLEN-1:0]       br_target,
    output logic                      stallreq
);

    logic [`ID_BR_KIND_WD-1:0] br_kind;

    id_fetch_latch i_fetch_latch (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_pc      (if_pc),
        .if_valid   (if_valid),
        .inst_rdata (inst_rdata),
        .id_pc      (id_pc),
        .id_valid   (id_valid),
        .id_inst    (id_inst)
    );

    id_regfile i_regfile (
        .clk    (clk),
        .raddr1 (id_inst.r.rs),
        .raddr2 (id_inst.r.rt),
        .we     (wb_we),
        .waddr  (wb_waddr),
        .wdata  (wb_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    id_decoder i_decoder (
        .id_inst    (id_inst),
        .id_valid   (id_valid),
        .ex_is_load (ex_is_load),
        .ex_waddr   (ex_waddr),
        .alu_op     (alu_op),
        .sel_src1   (sel_src1),
        .sel_src2   (sel_src2),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .br_kind    (br_kind),
        .stallreq   (stallreq)
    );

    id_branch_unit i_branch_unit (
        .br_kind   (br_kind),
        .id_inst   (id_inst),
        .id_pc     (id_pc),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

endmodule

// ==== id_stage_asserts.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module id_stage_asserts (
    input logic                     clk,
    input logic                     rst,
    input logic                     id_valid,
    input logic [`ID_ALU_OP_WD-1:0] alu_op,
    input logic                     mem_en,
    input logic                     mem_we,
    input logic                     rf_we,
    input logic                     br_taken,
    input logic                     stallreq
);

    alu_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(alu_op))
        else $error("alu_op has more than one bit set");

    // nothing may fire out of an empty stage
    ctl_needs_valid: assert property (@(posedge clk) disable iff (rst)
        (br_taken || stallreq || rf_we) |-> id_valid)
        else $error("control active while id_valid is low");

    store_needs_en: assert property (@(posedge clk) disable iff (rst) mem_we |-> mem_en)
        else $error("mem_we without mem_en");

    valid_after_rst: assert property (@(posedge clk) rst |=> !id_valid)
        else $error("id_valid high after reset");

endmodule

bind id_stage id_stage_asserts i_asserts (
    .clk      (clk),
    .rst      (rst),
    .id_valid (id_valid),
    .alu_op   (alu_op),
    .mem_en   (mem_en),
    .mem_we   (mem_we),
    .rf_we    (rf_we),
    .br_taken (br_taken),
    .stallreq (stallreq)
);

// ==== tb_id_stage.sv ====
`timescale 1ns/1ps
`include "id_macros.svh"

module tb_id_stage;

    typedef struct packed {
        logic [`ID_ALU_OP_WD-1:0] alu;
        logic [`ID_SRC1_WD-1:0]   s1;
        logic [`ID_SRC2_WD-1:0]   s2;
        logic                     men, mwe, we, taken, sreq;
        logic [`ID_RADDR_WD-1:0]  waddr;
        logic [`ID_XLEN-1:0]      target, rd1, rd2;
    } exp_t;

    logic clk, rst, if_valid, wb_we, ex_is_load;
    logic [`ID_STALL_WD-1:0] stall;
    logic [`ID_XLEN-1:0] if_pc, inst_rdata, wb_wdata;
    logic [`ID_RADDR_WD-1:0] wb_waddr, ex_waddr;
    logic id_valid, mem_en, mem_we, rf_we, br_taken, stallreq;
    logic [`ID_XLEN-1:0] id_pc, rdata1, rdata2, br_target;
    id_pkg::inst_u id_inst;
    logic [`ID_ALU_OP_WD-1:0] alu_op;
    logic [`ID_SRC1_WD-1:0] sel_src1;
    logic [`ID_SRC2_WD-1:0] sel_src2;
    logic [`ID_RADDR_WD-1:0] rf_waddr;

    logic [`ID_XLEN-1:0] mirror [0:31];
    integer seed = 32'h0f12_ad17;
    integer cycles = 0;
    logic pend_valid = 1'b0, stg_valid = 1'b0;
    logic [`ID_XLEN-1:0] pend_pc, pend_word, stg_pc, stg_word, pc;

    id_stage i_id_stage (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (wb_we && wb_waddr != '0) begin
            mirror[wb_waddr] <= wb_wdata;
        end
        if (cycles >= 2000) begin
            $display("timeout: test did not finish");
            $display("Something failed");
            $fatal(1);
        end
    end

    task automatic report_fail(input string name, input logic [`ID_XLEN-1:0] exp, act);
        $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [`ID_XLEN-1:0] exp, act);
        if (act !== exp) report_fail(name, exp, act);
    endtask

    task automatic check_alu(input string name, input logic [`ID_ALU_OP_WD-1:0] exp, act);
        if (act !== exp) report_fail(name, exp, act);
    endtask

    task automatic check_sel(input string name, input logic [`ID_SRC2_WD-1:0] exp, act);
        if (act !== exp) report_fail(name, exp, act);
    endtask

    task automatic check_reg(input string name, input logic [`ID_RADDR_WD-1:0] exp, act);
        if (act !== exp) report_fail(name, exp, act);
    endtask

    task automatic check_bit(input string name, input logic exp, act);
        if (act !== exp) report_fail(name, exp, act);
    endtask

    // r0 reads zero and a write-back in flight overrides the mirror
    function automatic logic [`ID_XLEN-1:0] read_reg(input logic [4:0] a);
        if (a == 0) return '0;
        if (wb_we && wb_waddr == a) return wb_wdata;
        return mirror[a];
    endfunction

    function automatic exp_t expect_decode(input logic [31:0] w, input logic [31:0] p,
                                           input logic ld, input logic [4:0] exa);
        exp_t e;
        logic [5:0] op, fn;
        logic [4:0] rs, rt, rd, sh;
        logic [31:0] npc, boff;
        logic [2:0] kind;
        op = w[31:26];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        sh = w[10:6];
        fn = w[5:0];
        e = '0;
        e.rd1 = read_reg(rs);
        e.rd2 = read_reg(rt);
        e.sreq = ld && (exa == rs || exa == rt);
        npc = p + 4;
        boff = {{14{w[15]}}, w[15:0], 2'b00};
        kind = 0;
        case (op)
            `ID_OP_SPECIAL: begin
                if (fn == `ID_FN_SLL || fn == `ID_FN_SRL || fn == `ID_FN_SRA) begin
                    if (rs == 0) begin
                        e.alu[fn == `ID_FN_SLL ? `ID_ALU_SLL :
                              fn == `ID_FN_SRL ? `ID_ALU_SRL : `ID_ALU_SRA] = 1'b1;
                        e.s1 = 3'b100;
                        e.s2 = 4'b0001;
                        e.we = 1'b1;
                        e.waddr = rd;
                    end
                end else if (sh == 0) begin
                    if (fn == `ID_FN_JR) begin
                        if (rt == 0 && rd == 0) kind = 6;
                    end else begin
                        case (fn)
                            `ID_FN_ADDU: e.alu[`ID_ALU_ADD] = 1'b1;
                            `ID_FN_SUBU: e.alu[`ID_ALU_SUB] = 1'b1;
                            `ID_FN_AND:  e.alu[`ID_ALU_AND] = 1'b1;
                            `ID_FN_OR:   e.alu[`ID_ALU_OR] = 1'b1;
                            `ID_FN_XOR:  e.alu[`ID_ALU_XOR] = 1'b1;
                            `ID_FN_NOR:  e.alu[`ID_ALU_NOR] = 1'b1;
                            `ID_FN_SLT:  e.alu[`ID_ALU_SLT] = 1'b1;
                            `ID_FN_SLTU: e.alu[`ID_ALU_SLTU] = 1'b1;
                            default: ;
                        endcase
                        if (e.alu != 0) begin
                            e.s1 = 3'b001;
                            e.s2 = 4'b0001;
                            e.we = 1'b1;
                            e.waddr = rd;
                        end
                    end
                end
            end
            `ID_OP_ADDIU, `ID_OP_SLTI, `ID_OP_SLTIU, `ID_OP_LW, `ID_OP_SW: begin
                e.alu[op == `ID_OP_SLTI ? `ID_ALU_SLT :
                      op == `ID_OP_SLTIU ? `ID_ALU_SLTU : `ID_ALU_ADD] = 1'b1;
                e.s1 = 3'b001;
                e.s2 = 4'b0010;
                e.men = (op == `ID_OP_LW || op == `ID_OP_SW);
                e.mwe = (op == `ID_OP_SW);
                e.we = (op != `ID_OP_SW);
                e.waddr = e.we ? rt : 5'd0;
            end
            `ID_OP_ANDI, `ID_OP_ORI, `ID_OP_XORI: begin
                e.alu[op == `ID_OP_ANDI ? `ID_ALU_AND :
                      op == `ID_OP_ORI ? `ID_ALU_OR : `ID_ALU_XOR] = 1'b1;
                e.s1 = 3'b001;
                e.s2 = 4'b1000;
                e.we = 1'b1;
                e.waddr = rt;
            end
            `ID_OP_LUI: begin
                e.alu[`ID_ALU_LUI] = 1'b1;
                e.s2 = 4'b0010;
                e.we = 1'b1;
                e.waddr = rt;
            end
            `ID_OP_BEQ: kind = 1;
            `ID_OP_BNE: kind = 2;
            `ID_OP_REGIMM: kind = (rt == `ID_RT_BGEZ) ? 3 : (rt == `ID_RT_BLTZ) ? 4 : 0;
            `ID_OP_J: kind = 5;
            `ID_OP_JAL: begin
                kind = 5;
                e.alu[`ID_ALU_ADD] = 1'b1;
                e.s1 = 3'b010;
                e.s2 = 4'b0100;
                e.we = 1'b1;
                e.waddr = `ID_LINK_REG;
            end
            default: ;
        endcase
        case (kind)
            1: e.taken = e.rd1 == e.rd2;
            2: e.taken = e.rd1 != e.rd2;
            3: e.taken = !e.rd1[31];
            4: e.taken = e.rd1[31];
            5, 6: e.taken = 1'b1;
            default: ;
        endcase
        if (kind >= 1 && kind <= 4) begin
            e.target = npc + boff;
        end else if (kind == 5) begin
            e.target = {npc[31:28], w[25:0], 2'b00};
        end else if (kind == 6) begin
            e.target = e.rd1;
        end
        return e;
    endfunction

    // full comparison whenever the modelled stage holds a valid word
    always @(negedge clk) begin
        exp_t e;
        if (!rst && stg_valid) begin
            e = expect_decode(stg_word, stg_pc, ex_is_load, ex_waddr);
            check_bit("id_valid", 1'b1, id_valid);
            check_word("id_pc", stg_pc, id_pc);
            check_word("id_inst", stg_word, id_inst);
            check_alu("alu_op", e.alu, alu_op);
            check_sel("sel_src1", {1'b0, e.s1}, {1'b0, sel_src1});
            check_sel("sel_src2", e.s2, sel_src2);
            check_bit("mem_en", e.men, mem_en);
            check_bit("mem_we", e.mwe, mem_we);
            check_bit("rf_we", e.we, rf_we);
            check_reg("rf_waddr", e.waddr, rf_waddr);
            check_word("rdata1", e.rd1, rdata1);
            check_word("rdata2", e.rd2, rdata2);
            check_bit("br_taken", e.taken, br_taken);
            check_word("br_target", e.target, br_target);
            check_bit("stallreq", e.sreq, stallreq);
        end
    end

    function automatic logic [31:0] gen_inst(input integer k);
        logic [4:0] rs, rt, rd, sh;
        logic [15:0] imm;
        logic [5:0] rfn [0:7];
        logic [5:0] iop [0:8];
        rfn = '{`ID_FN_ADDU, `ID_FN_SUBU, `ID_FN_AND, `ID_FN_OR,
                `ID_FN_XOR, `ID_FN_NOR, `ID_FN_SLT, `ID_FN_SLTU};
        iop = '{`ID_OP_ADDIU, `ID_OP_SLTI, `ID_OP_SLTIU, `ID_OP_ANDI, `ID_OP_ORI,
                `ID_OP_XORI, `ID_OP_LUI, `ID_OP_LW, `ID_OP_SW};
        rs = $random(seed);
        rt = $random(seed);
        rd = $random(seed);
        sh = $random(seed);
        imm = $random(seed);
        if (k < 8) return {`ID_OP_SPECIAL, rs, rt, rd, 5'd0, rfn[k]};
        if (k == 8) return {`ID_OP_SPECIAL, 5'd0, rt, rd, sh, `ID_FN_SLL};
        if (k == 9) return {`ID_OP_SPECIAL, 5'd0, rt, rd, sh, `ID_FN_SRL};
        if (k == 10) return {`ID_OP_SPECIAL, 5'd0, rt, rd, sh, `ID_FN_SRA};
        if (k == 11) return {`ID_OP_SPECIAL, rs, 15'd0, `ID_FN_JR};
        if (k < 21) return {iop[k-12], rs, rt, imm};
        if (k == 21) return {`ID_OP_BEQ, rs, rt, imm};
        if (k == 22) return {`ID_OP_BNE, rs, rt, imm};
        if (k == 23) return {`ID_OP_REGIMM, rs, `ID_RT_BGEZ, imm};
        if (k == 24) return {`ID_OP_REGIMM, rs, `ID_RT_BLTZ, imm};
        if (k == 25) return {`ID_OP_J, rs, rt, imm};
        if (k == 26) return {`ID_OP_JAL, rs, rt, imm};
        return $random(seed);
    endfunction

    // one-deep memory presents each word one edge after its pc
    task automatic issue(input logic [31:0] p, input logic [31:0] w, input logic v);
        @(posedge clk);
        if_pc <= p;
        if_valid <= v;
        inst_rdata <= pend_word;
        wb_we <= $random(seed);
        wb_waddr <= ($random(seed) & 3) == 0 ? pend_word[25:21] : $random(seed);
        wb_wdata <= $random(seed);
        ex_is_load <= $random(seed);
        ex_waddr <= ($random(seed) & 1) ? pend_word[20:16] : $random(seed);
        stg_valid = pend_valid;
        stg_pc = pend_pc;
        stg_word = pend_word;
        pend_valid = v;
        pend_pc = p;
        pend_word = w;
    endtask

    task automatic stall_test();
        logic [31:0] w;
        w = gen_inst(0);
        issue(0, 0, 0);
        issue(0, 0, 0);
        @(posedge clk);
        stg_valid = 1'b0;
        if_pc <= 32'h0000_4000;
        if_valid <= 1'b1;
        @(posedge clk);
        inst_rdata <= w;
        if_pc <= 32'h0000_4004;
        stall <= 6'b000110;
        repeat (5) begin
            @(negedge clk);
            check_word("id_pc", 32'h0000_4000, id_pc);
            check_word("id_inst", w, id_inst);
            check_bit("id_valid", 1'b1, id_valid);
            @(posedge clk);
            inst_rdata <= $random(seed);
        end
        stall <= 6'b000010;
        ex_is_load <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit("id_valid", 1'b0, id_valid);
        check_alu("alu_op", '0, alu_op);
        check_sel("sel_src1", '0, {1'b0, sel_src1});
        check_sel("sel_src2", '0, sel_src2);
        check_bit("mem_en", 1'b0, mem_en);
        check_bit("mem_we", 1'b0, mem_we);
        check_bit("rf_we", 1'b0, rf_we);
        check_reg("rf_waddr", '0, rf_waddr);
        check_bit("br_taken", 1'b0, br_taken);
        check_bit("stallreq", 1'b0, stallreq);
        @(posedge clk);
        stall <= '0;
        if_valid <= 1'b0;
        pend_valid = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        stall = '0;
        if_pc = '0;
        if_valid = 1'b0;
        inst_rdata = '0;
        wb_we = 1'b0;
        wb_waddr = '0;
        wb_wdata = '0;
        ex_is_load = 1'b0;
        ex_waddr = '0;
        pend_word = '0;
        pend_pc = '0;
        for (int i = 0; i < 32; i++) mirror[i] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            wb_we <= 1'b1;
            wb_waddr <= i;
            wb_wdata <= $random(seed);
        end
        pc = 32'hbfc0_0000;
        for (int n = 0; n < 400; n++) begin
            issue(pc, gen_inst($unsigned($random(seed)) % 28), 1'b1);
            pc = pc + 4;
        end
        for (int k = 21; k < 28; k++) begin
            issue(pc, gen_inst(k), 1'b1);
            issue(pc + 4, gen_inst(11), 1'b1);
            issue(pc + 8, 32'hfc00_0000 | k, 1'b1);
            pc = pc + 12;
        end
        stall_test();
        issue(0, 0, 0);
        issue(0, 0, 0);
        @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule
